//--- Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_way.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/tb_dcache.sv

//--- project.f
verilog/dcache_pkg.sv
verilog/dcache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

//--- tests/mem_model.sv
/* burst memory for the cache testbench, 64 KiB store, upper address bits ignored
   ready and valid stall at random, write responses are always okay */
`default_nettype none

module mem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  dcache_pkg::mem_addr_t  ar_i,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output dcache_pkg::mem_rbeat_t r_o,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  dcache_pkg::mem_addr_t  aw_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  dcache_pkg::mem_wbeat_t w_i,
  output logic                   b_valid_o,
  input  logic                   b_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  logic [7:0]  store [65536];
  int          seed = 32'he986ea7c;
  logic        rd_busy;
  logic [15:0] rd_addr;
  logic        rd_beat;
  logic        r_taken;  // beat accepted on the last rising edge
  logic [15:0] wr_addr;
  logic        wr_beat;
  logic        b_pend;
  logic        b_taken;

  // three times out of four
  function automatic logic coin();
    return (($random(seed) & 3) != 0);
  endfunction

  function automatic logic [63:0] read_word(input logic [15:0] addr, input logic beat);
    logic [63:0] w;
    int          b;
    for (b = 0; b < 8; b++) begin
      w[b*8 +: 8] = store[{addr[15:4], beat, 3'b000} + b];
    end
    return w;
  endfunction

  initial begin
    int a;
    for (a = 0; a < 65536; a++) begin
      store[a] = 8'(a + (a >> 8) * 13 + 'h5a);  // every address bit counts
    end
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
  end

  // handshakes as seen at the rising edge
  always @(posedge clk) begin
    r_taken <= r_valid_o && r_ready_i;
    b_taken <= b_valid_o && b_ready_i;
    if (rst) begin
      rd_busy <= 1'b0;
      rd_beat <= 1'b0;
      wr_beat <= 1'b0;
      b_pend  <= 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        rd_busy <= 1'b1;
        rd_addr <= ar_i.addr[15:0];
        rd_beat <= 1'b0;
      end
      if (r_valid_o && r_ready_i) begin
        rd_beat <= 1'b1;
        if (rd_beat) begin
          rd_busy <= 1'b0;  // second beat done
        end
      end
      if (aw_valid_i && aw_ready_o) begin
        wr_addr <= aw_i.addr[15:0];
        wr_beat <= 1'b0;
      end
      if (w_valid_i && w_ready_o) begin
        for (int b = 0; b < 8; b++) begin
          if (w_i.strb[b]) begin
            store[{wr_addr[15:4], wr_beat, 3'b000} + b] <= w_i.data[b*8 +: 8];
          end
        end
        wr_beat <= 1'b1;
        if (w_i.last) begin
          b_pend <= 1'b1;
        end
      end
      if (b_valid_o && b_ready_i) begin
        b_pend <= 1'b0;
      end
    end
  end

  // outputs change on the falling edge, a raised valid holds until taken
  always @(negedge clk) begin
    ar_ready_o <= !rd_busy && coin();
    aw_ready_o <= coin();
    w_ready_o  <= coin();
    if (!r_valid_o || r_taken) begin
      r_valid_o <= rd_busy && coin();
    end
    if (!b_valid_o || b_taken) begin
      b_valid_o <= b_pend && coin();
    end
    r_o.data <= read_word(rd_addr, rd_beat);
    r_o.last <= rd_beat;
  end

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
/* testbench for the two-way data cache, table driven, one request at a time
   expected reads come from a shadow copy of the memory model's store */
`default_nettype none

module tb_dcache;
  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  localparam int N_OPS       = 13;
  localparam int CYCLE_LIMIT = N_OPS * 40 + 200;

  typedef struct packed {
    logic        write;
    logic        hit;    // expected to hit
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;
    logic [3:0]  stall;  // cycles with rsp_ready_i low
  } op_t;

  logic        clk;
  logic        rst;
  logic        req_valid_i;
  logic        req_ready_o;
  cache_req_t  req_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  cache_rsp_t  rsp_o;
  logic        ar_valid;
  logic        ar_ready;
  logic        r_valid;
  logic        r_ready;
  logic        aw_valid;
  logic        aw_ready;
  logic        w_valid;
  logic        w_ready;
  logic        b_valid;
  logic        b_ready;
  mem_addr_t   ar;
  mem_addr_t   aw;
  mem_rbeat_t  r;
  mem_wbeat_t  w;

  op_t         ops [N_OPS];
  int          n_ops = 0;
  logic [7:0]  shadow [65536];
  int          errors = 0;
  int          cycles = 0;

  dcache_top #(.INDEX_WIDTH(6)) UUT (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
    .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_o(ar),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_i(r),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_o(aw),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_o(w),
    .b_valid_i(b_valid), .b_ready_o(b_ready)
  );

  mem_model memory (
    .clk(clk), .rst(rst),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_i(ar),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_o(r),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_i(aw),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_i(w),
    .b_valid_o(b_valid), .b_ready_i(b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the cache did not finish the table within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic add_op(input logic w_en, input logic hit, input logic [31:0] addr,
                        input logic [63:0] data, input logic [7:0] strb, input int stall);
    ops[n_ops] = {w_en, hit, addr, data, strb, 4'(stall)};
    n_ops++;
  endtask

  function automatic logic [63:0] shadow_word(input logic [31:0] addr);
    logic [63:0] wd;
    int          b;
    for (b = 0; b < 8; b++) begin
      wd[b*8 +: 8] = shadow[{addr[15:3], 3'b000} + b];
    end
    return wd;
  endfunction

  // called and returns just after a falling edge
  task automatic apply_op(input op_t op);
    cache_rsp_t first_rsp;
    int         lat;
    int         i;
    req_valid_i = 1'b1;
    req_i.write = op.write;
    req_i.addr  = op.addr;
    req_i.wdata = op.data;
    req_i.strb  = op.strb;
    while (!req_ready_o) @(negedge clk);
    @(negedge clk);  // accepted on the edge just passed
    req_valid_i = 1'b0;
    if (op.write) begin
      for (i = 0; i < 8; i++) begin
        if (op.strb[i]) shadow[{op.addr[15:3], 3'b000} + i] = op.data[i*8 +: 8];
      end
    end
    lat = 0;
    while (!rsp_valid_o) begin
      @(negedge clk);
      lat++;
    end
    if (op.hit) check("hit latency", lat, 2);
    check("req_ready_o", req_ready_o, 1'b0);
    check("rsp_o.wack", rsp_o.wack, op.write);
    if (!op.write) check("rsp_o.rdata", rsp_o.rdata, shadow_word(op.addr));
    first_rsp = rsp_o;
    for (i = 0; i < op.stall; i++) begin
      @(negedge clk);
      check("rsp_valid_o", rsp_valid_o, 1'b1);
      check("rsp_o", rsp_o, first_rsp);
      check("req_ready_o", req_ready_o, 1'b0);
    end
    rsp_ready_i = 1'b1;
    @(negedge clk);
    rsp_ready_i = 1'b0;
    check("rsp_valid_o", rsp_valid_o, 1'b0);
    check("req_ready_o", req_ready_o, 1'b1);
  endtask

  initial begin
    int i;
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    add_op(0, 0, 32'h0000_1000, 64'h0, 8'h00, 0);  // cold miss in set 0
    add_op(0, 1, 32'h0000_1008, 64'h0, 8'h00, 0);
    add_op(0, 1, 32'h0000_1000, 64'h0, 8'h00, 3);
    add_op(1, 1, 32'h0000_1008, 64'h1122_3344_5566_7788, 8'b0011_0101, 0);
    add_op(0, 1, 32'h0000_1008, 64'h0, 8'h00, 1);
    // three tags in set 4, the third evicts the first
    add_op(1, 0, 32'h0000_2040, 64'hdead_beef_0bad_f00d, 8'hf0, 0);
    add_op(1, 0, 32'h0000_3048, 64'hcafe_babe_1234_5678, 8'hff, 0);
    add_op(1, 0, 32'h0000_4040, 64'h0f0e_0d0c_0b0a_0908, 8'h3c, 0);
    add_op(0, 0, 32'h0000_2040, 64'h0, 8'h00, 2);  // evicts the second
    add_op(0, 1, 32'h0000_4040, 64'h0, 8'h00, 0);
    add_op(0, 1, 32'h0000_2048, 64'h0, 8'h00, 0);
    add_op(0, 0, 32'h0000_a5b8, 64'h0, 8'h00, 1);
    add_op(0, 1, 32'h0000_1008, 64'h0, 8'h00, 0);
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < 65536; i++) begin
      shadow[i] = memory.store[i];
    end
    @(negedge clk);
    check("req_ready_o", req_ready_o, 1'b1);
    check("rsp_valid_o", rsp_valid_o, 1'b0);
    check("ar_valid_o", ar_valid, 1'b0);
    check("aw_valid_o", aw_valid, 1'b0);
    check("w_valid_o", w_valid, 1'b0);
    check("r_ready_o", r_ready, 1'b0);
    check("b_ready_o", b_ready, 1'b0);
    for (i = 0; i < n_ops; i++) begin
      apply_op(ops[i]);
    end
    // both evicted lines must sit in the memory store
    for (i = 0; i < 16; i++) begin
      check($sformatf("store[%0h]", 16'h2040 + i), memory.store[16'h2040 + i],
            shadow[16'h2040 + i]);
      check($sformatf("store[%0h]", 16'h3040 + i), memory.store[16'h3040 + i],
            shadow[16'h3040 + i]);
    end
    $display("errors: %0d in %0d operations", errors, n_ops);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
/* cache controller, one request in flight, hit response two cycles after accept
   memory error responses are not looked at, victim pointer flips on every miss */
`default_nettype none

module dcache_ctrl #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                                               clk,
  input  logic                                               rst,

  input  logic                                               req_valid_i,
  output logic                                               req_ready_o,
  input  dcache_pkg::cache_req_t                             req_i,
  output logic                                               rsp_valid_o,
  input  logic                                               rsp_ready_i,
  output dcache_pkg::cache_rsp_t                             rsp_o,

  output logic [INDEX_WIDTH-1:0]                             lookup_index_o,
  output logic [dcache_pkg::LINE_ADDR_WIDTH-INDEX_WIDTH-1:0] lookup_tag_o,
  output logic [INDEX_WIDTH-1:0]                             wr_index_o,
  output dcache_pkg::way_write_t                             way0_wr_o,
  output dcache_pkg::way_write_t                             way1_wr_o,
  input  dcache_pkg::way_status_t                            way0_status_i,
  input  dcache_pkg::way_status_t                            way1_status_i,

  output logic                                               ar_valid_o,
  input  logic                                               ar_ready_i,
  output dcache_pkg::mem_addr_t                              ar_o,
  input  logic                                               r_valid_i,
  output logic                                               r_ready_o,
  input  dcache_pkg::mem_rbeat_t                             r_i,
  output logic                                               aw_valid_o,
  input  logic                                               aw_ready_i,
  output dcache_pkg::mem_addr_t                              aw_o,
  output logic                                               w_valid_o,
  input  logic                                               w_ready_i,
  output dcache_pkg::mem_wbeat_t                             w_o,
  input  logic                                               b_valid_i,
  output logic                                               b_ready_o
);

  import dcache_pkg::*;

  localparam int TAG_WIDTH = LINE_ADDR_WIDTH - INDEX_WIDTH;

  ctrl_state_e           state_q;
  ctrl_state_e           state_d;
  cache_req_t            req_q;
  cache_rsp_t            rsp_q;

  logic                  lookup_wait_q;  // first LOOKUP cycle, ways still reading
  logic                  way_q;          // way being refilled
  logic                  victim_q;
  logic                  beat_q;

  logic                  word_sel;
  logic                  any_hit;
  logic                  hit_way;
  logic                  decide;
  logic                  vic_dirty;
  logic                  merge_beat;
  logic                  tgt_way;
  logic [LINE_WIDTH-1:0] hit_line;
  logic [DATA_WIDTH-1:0] hit_word;
  logic [DATA_WIDTH-1:0] fill_word;
  way_status_t           wb_status;
  way_write_t            wr_cmd;

  logic                  req_hs;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  ar_hs;
  logic                  r_hs;

  assign req_hs = req_valid_i && req_ready_o;
  assign aw_hs  = aw_valid_o && aw_ready_i;
  assign w_hs   = w_valid_o && w_ready_i;
  assign ar_hs  = ar_valid_o && ar_ready_i;
  assign r_hs   = r_valid_i && r_ready_o;

  // both ways see the latched request address
  assign lookup_index_o = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign lookup_tag_o   = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign wr_index_o     = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];

  assign word_sel = req_q.addr[OFFSET_WIDTH-1];  // upper word of the line
  assign any_hit  = way0_status_i.hit || way1_status_i.hit;
  assign hit_way  = way1_status_i.hit;
  assign decide   = (state_q == LOOKUP) && !lookup_wait_q;

  assign hit_line = hit_way ? way1_status_i.line : way0_status_i.line;
  assign hit_word = word_sel ? hit_line[LINE_WIDTH-1:DATA_WIDTH] : hit_line[DATA_WIDTH-1:0];

  assign vic_dirty = victim_q ? (way1_status_i.valid && way1_status_i.dirty)
                              : (way0_status_i.valid && way0_status_i.dirty);
  assign wb_status = way_q ? way1_status_i : way0_status_i;

  // fill beat with the pending write bytes laid over it
  assign merge_beat = req_q.write && (beat_q == word_sel);
  always_comb begin
    for (int b = 0; b < STRB_WIDTH; b++) begin
      fill_word[b*8 +: 8] = (merge_beat && req_q.strb[b]) ? req_q.wdata[b*8 +: 8]
                                                          : r_i.data[b*8 +: 8];
    end
  end

  // handshake outputs follow the state directly
  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_o       = rsp_q;
  assign aw_valid_o  = (state_q == WB_ADDR);
  assign w_valid_o   = (state_q == WB_DATA);
  assign b_ready_o   = (state_q == WB_RESP);
  assign ar_valid_o  = (state_q == FILL_ADDR);
  assign r_ready_o   = (state_q == FILL_DATA);

  assign aw_o.addr = {wb_status.line_addr, {OFFSET_WIDTH{1'b0}}};
  assign ar_o.addr = {req_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

  assign w_o.data = beat_q ? wb_status.line[LINE_WIDTH-1:DATA_WIDTH]
                           : wb_status.line[DATA_WIDTH-1:0];
  assign w_o.strb = {STRB_WIDTH{1'b1}};
  assign w_o.last = beat_q;

  // next state and the way write command
  always_comb begin
    state_d = state_q;
    wr_cmd  = '0;
    tgt_way = way_q;
    case (state_q)
      IDLE: begin
        if (req_hs) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (decide) begin
          if (any_hit) begin
            tgt_way          = hit_way;
            wr_cmd.we        = req_q.write;
            wr_cmd.beat      = word_sel;
            wr_cmd.data      = req_q.wdata;
            wr_cmd.strb      = req_q.strb;
            wr_cmd.set_dirty = req_q.write;
            state_d          = RESPOND;
          end else if (vic_dirty) begin
            state_d = WB_ADDR;
          end else begin
            state_d = FILL_ADDR;
          end
        end
      end
      RESPOND: begin
        if (rsp_ready_i) begin
          state_d = IDLE;
        end
      end
      WB_ADDR: begin
        if (aw_hs) begin
          state_d = WB_DATA;
        end
      end
      WB_DATA: begin
        if (w_hs && beat_q) begin
          state_d = WB_RESP;
        end
      end
      WB_RESP: begin
        if (b_valid_i) begin
          state_d = FILL_ADDR;
        end
      end
      FILL_ADDR: begin
        // new tag goes in once the old line is out, line stays invalid
        wr_cmd.load_tag  = ar_hs;
        wr_cmd.clr_valid = ar_hs;
        wr_cmd.line_addr = req_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH];
        if (ar_hs) begin
          state_d = FILL_DATA;
        end
      end
      FILL_DATA: begin
        if (r_hs) begin
          wr_cmd.we        = 1'b1;
          wr_cmd.beat      = beat_q;
          wr_cmd.data      = fill_word;
          wr_cmd.strb      = {STRB_WIDTH{1'b1}};
          wr_cmd.set_dirty = merge_beat;
          wr_cmd.set_valid = r_i.last;
          if (r_i.last) begin
            state_d = RESPOND;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign way0_wr_o = tgt_way ? way_write_t'('0) : wr_cmd;
  assign way1_wr_o = tgt_way ? wr_cmd : way_write_t'('0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= IDLE;
      lookup_wait_q <= 1'b0;
      way_q         <= 1'b0;
      victim_q      <= 1'b0;
      beat_q        <= 1'b0;
    end else begin
      state_q       <= state_d;
      lookup_wait_q <= req_hs;
      if (decide && !any_hit) begin
        way_q    <= victim_q;
        victim_q <= ~victim_q;  // advance on every miss
      end
      if (aw_hs || ar_hs) begin
        beat_q <= 1'b0;
      end else if (w_hs || r_hs) begin
        beat_q <= ~beat_q;
      end
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (req_hs) begin
      req_q <= req_i;
    end
    if (decide && any_hit) begin
      rsp_q.rdata <= hit_word;
      rsp_q.wack  <= req_q.write;
    end else if (r_hs && (beat_q == word_sel)) begin
      rsp_q.rdata <= fill_word;  // merged word for a write miss
      rsp_q.wack  <= req_q.write;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
/* shared widths and structs for the two-way data cache
   lines are 16 bytes in two 64-bit words, addresses are 32-bit byte addresses */
`default_nettype none

package dcache_pkg;

  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 64;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int OFFSET_WIDTH    = 4;
  localparam int LINE_WIDTH      = 2 * DATA_WIDTH;
  localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

  // core side
  typedef struct packed {
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] strb;
  } cache_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  wack;  // set for a write request
  } cache_rsp_t;

  // memory side
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } mem_addr_t;  // serves both ar and aw

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } mem_wbeat_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } mem_rbeat_t;

  // way to controller
  typedef struct packed {
    logic                       hit;
    logic                       valid;
    logic                       dirty;
    logic [LINE_ADDR_WIDTH-1:0] line_addr;  // tag and index of the stored line
    logic [LINE_WIDTH-1:0]      line;
  } way_status_t;

  // controller to way
  typedef struct packed {
    logic                       we;         // word write under strb
    logic                       beat;       // 0 low word, 1 high word
    logic [DATA_WIDTH-1:0]      data;
    logic [STRB_WIDTH-1:0]      strb;
    logic                       set_dirty;
    logic                       load_tag;   // also clears dirty
    logic [LINE_ADDR_WIDTH-1:0] line_addr;
    logic                       set_valid;
    logic                       clr_valid;
  } way_write_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    RESPOND,
    WB_ADDR,
    WB_DATA,
    WB_RESP,
    FILL_ADDR,
    FILL_DATA
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/dcache_top.sv
/* two-way write-back data cache, one core request at a time
   INDEX_WIDTH sets the number of sets, lines are fetched as two-beat bursts */
`default_nettype none

module dcache_top #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                   clk,
  input  logic                   rst,

  // core side
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  dcache_pkg::cache_req_t req_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output dcache_pkg::cache_rsp_t rsp_o,

  // memory side
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output dcache_pkg::mem_addr_t  ar_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  dcache_pkg::mem_rbeat_t r_i,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output dcache_pkg::mem_addr_t  aw_o,
  output logic                   w_valid_o,
  input  logic                   w_ready_i,
  output dcache_pkg::mem_wbeat_t w_o,
  input  logic                   b_valid_i,
  output logic                   b_ready_o
);

  import dcache_pkg::*;

  logic [INDEX_WIDTH-1:0]                 lookup_index;
  logic [LINE_ADDR_WIDTH-INDEX_WIDTH-1:0] lookup_tag;
  logic [INDEX_WIDTH-1:0]                 wr_index;
  way_write_t                             way0_wr;
  way_write_t                             way1_wr;
  way_status_t                            way0_status;
  way_status_t                            way1_status;

  dcache_way #(
    .INDEX_WIDTH(INDEX_WIDTH)
  ) way0 (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .wr_index_i     (wr_index),
    .wr_i           (way0_wr),
    .status_o       (way0_status)
  );

  dcache_way #(
    .INDEX_WIDTH(INDEX_WIDTH)
  ) way1 (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .wr_index_i     (wr_index),
    .wr_i           (way1_wr),
    .status_o       (way1_status)
  );

  dcache_ctrl #(
    .INDEX_WIDTH(INDEX_WIDTH)
  ) ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o),
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .wr_index_o     (wr_index),
    .way0_wr_o      (way0_wr),
    .way1_wr_o      (way1_wr),
    .way0_status_i  (way0_status),
    .way1_status_i  (way1_status),
    .ar_valid_o     (ar_valid_o),
    .ar_ready_i     (ar_ready_i),
    .ar_o           (ar_o),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .r_i            (r_i),
    .aw_valid_o     (aw_valid_o),
    .aw_ready_i     (aw_ready_i),
    .aw_o           (aw_o),
    .w_valid_o      (w_valid_o),
    .w_ready_i      (w_ready_i),
    .w_o            (w_o),
    .b_valid_i      (b_valid_i),
    .b_ready_o      (b_ready_o)
  );

endmodule

`default_nettype wire

//--- verilog/dcache_way.sv
/* one cache way: tag, valid, dirty and 128-bit line per set
   status reflects the set index registered on the previous edge, writes show at once */
`default_nettype none

module dcache_way #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [INDEX_WIDTH-1:0]                             lookup_index_i,
  input  logic [dcache_pkg::LINE_ADDR_WIDTH-INDEX_WIDTH-1:0] lookup_tag_i,
  input  logic [INDEX_WIDTH-1:0]                             wr_index_i,
  input  dcache_pkg::way_write_t                             wr_i,
  output dcache_pkg::way_status_t                            status_o
);

  import dcache_pkg::*;

  localparam int TAG_WIDTH = LINE_ADDR_WIDTH - INDEX_WIDTH;
  localparam int SETS      = 1 << INDEX_WIDTH;
  localparam int LINE_BYTES = LINE_WIDTH / 8;

  logic [TAG_WIDTH-1:0]   tag_mem  [SETS];
  logic [LINE_WIDTH-1:0]  data_mem [SETS];
  logic [SETS-1:0]        valid_q;
  logic [SETS-1:0]        dirty_q;

  logic [INDEX_WIDTH-1:0] rd_index_q;
  logic [TAG_WIDTH-1:0]   rd_tag_q;

  logic [LINE_WIDTH-1:0]  wr_line;
  logic [LINE_BYTES-1:0]  wr_be;

  // word replicated in both halves, byte enables pick the half
  assign wr_line = {2{wr_i.data}};
  assign wr_be   = wr_i.beat ? {wr_i.strb, {STRB_WIDTH{1'b0}}}
                             : {{STRB_WIDTH{1'b0}}, wr_i.strb};

  // state bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (wr_i.clr_valid) begin
        valid_q[wr_index_i] <= 1'b0;
      end
      if (wr_i.set_valid) begin
        valid_q[wr_index_i] <= 1'b1;
      end
      if (wr_i.load_tag) begin
        dirty_q[wr_index_i] <= 1'b0;  // fresh line starts clean
      end
      if (wr_i.set_dirty) begin
        dirty_q[wr_index_i] <= 1'b1;
      end
    end
  end

  // tag and data storage, plus the lookup register
  always_ff @(posedge clk) begin
    rd_index_q <= lookup_index_i;
    rd_tag_q   <= lookup_tag_i;
    if (wr_i.load_tag) begin
      tag_mem[wr_index_i] <= wr_i.line_addr[LINE_ADDR_WIDTH-1:INDEX_WIDTH];
    end
    if (wr_i.we) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_be[b]) begin
          data_mem[wr_index_i][b*8 +: 8] <= wr_line[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    status_o.valid     = valid_q[rd_index_q];
    status_o.dirty     = dirty_q[rd_index_q];
    status_o.hit       = valid_q[rd_index_q] && (tag_mem[rd_index_q] == rd_tag_q);
    status_o.line_addr = {tag_mem[rd_index_q], rd_index_q};
    status_o.line      = data_mem[rd_index_q];
  end

endmodule

`default_nettype wire
